// File: csr_index_generator.f
hw/csr_index_generator_pkg.sv
hw/response_window_filter.sv
hw/config_sequence_tracker.sv
hw/config_field_decoder.sv
hw/config_output_fifo.sv
hw/csr_index_generator.sv
bench/csr_index_generator_assertions.sv
bench/csr_index_generator_tb.sv

// File: Makefile
TOP := csr_index_generator_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): csr_index_generator.f $(wildcard hw/*.sv) $(wildcard bench/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f csr_index_generator.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/csr_index_generator_tb.sv
// ----------------------------
// Directed testbench for the CSR index
// configuration loader: clock, reset,
// LCG word source, expected word queue
// ----------------------------

module csr_index_generator_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam csr_index_generator_pkg::offset_t BASE = 16'd64;
    // Twice the estimate of reset, 28 sequences, 25 drains and idle checks
    localparam int CYCLE_LIMIT = 2 * (10 + 28 * 10 + 25 * 8 + 40);

    logic                                   ap_clk;
    logic                                   areset_csr_index_generator;
    logic                                   resp_valid;
    csr_index_generator_pkg::offset_t       resp_offset;
    csr_index_generator_pkg::data_word_t    resp_data;
    logic                                   cfg_ready;
    logic                                   cfg_valid;
    csr_index_generator_pkg::flags_t        cfg_flags;
    csr_index_generator_pkg::index_t        cfg_index_start;
    csr_index_generator_pkg::index_t        cfg_index_end;
    csr_index_generator_pkg::index_t        cfg_stride;
    csr_index_generator_pkg::granularity_t  cfg_granularity;
    logic                                   cfg_direction;
    csr_index_generator_pkg::cmd_t          cfg_command;
    csr_index_generator_pkg::buffer_id_t    cfg_buffer_id;
    csr_index_generator_pkg::index_t        cfg_array_size;
    logic                                   overflow;

    logic [31:0]                            lcg_state;
    int                                     cycle_count;
    csr_index_generator_pkg::data_word_t    seq_words [8];
    // Eight words per expected configuration in arrival order
    csr_index_generator_pkg::data_word_t    exp_words [$];

    csr_index_generator #(.SEQ_BASE(BASE)) uut (.*);

    initial begin
        ap_clk = 1'b0;
        forever #2 ap_clk = ~ap_clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge ap_clk);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
        $display("=== FAIL ===");
        $fatal(1, "timeout");
    end

    // Halves swapped so the narrow low fields see the better high bits
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    // ----------------------------
    // Compare tasks
    // ----------------------------
    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAILED at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        $display("=== FAIL ===");
        $fatal(1, "value mismatch");
    endtask

    task automatic compare_index(input csr_index_generator_pkg::index_t got,
                                 input csr_index_generator_pkg::index_t exp, input string name);
        if (got !== exp) report_mismatch(name, got, exp);
    endtask

    task automatic compare_flags(input csr_index_generator_pkg::flags_t got,
                                 input csr_index_generator_pkg::flags_t exp, input string name);
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic compare_granularity(input csr_index_generator_pkg::granularity_t got,
                                       input csr_index_generator_pkg::granularity_t exp,
                                       input string name);
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic compare_cmd(input csr_index_generator_pkg::cmd_t got,
                               input csr_index_generator_pkg::cmd_t exp, input string name);
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic compare_buffer_id(input csr_index_generator_pkg::buffer_id_t got,
                                     input csr_index_generator_pkg::buffer_id_t exp,
                                     input string name);
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string name);
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    // ----------------------------
    // Stimulus and response helpers
    // ----------------------------
    task automatic fill_words();
        foreach (seq_words[i]) seq_words[i] = lcg_next();
    endtask

    task automatic send_response(input csr_index_generator_pkg::offset_t offset,
                                 input csr_index_generator_pkg::data_word_t data);
        @(posedge ap_clk);
        resp_valid  <= 1'b1;
        resp_offset <= offset;
        resp_data   <= data;
    endtask

    task automatic send_words(input int first, input int last);
        for (int i = first; i <= last; i++) begin
            send_response(csr_index_generator_pkg::offset_t'(BASE + i), seq_words[i]);
        end
    endtask

    task automatic stop_responses();
        @(posedge ap_clk);
        resp_valid <= 1'b0;
    endtask

    task automatic run_sequence(input logic keep);
        fill_words();
        send_words(0, 7);
        stop_responses();
        if (keep) begin
            foreach (seq_words[i]) exp_words.push_back(seq_words[i]);
        end
    endtask

    // Checks the head against the slicing rule, then pops it after a gap
    task automatic receive_config(input int gap);
        csr_index_generator_pkg::data_word_t w [8];
        @(negedge ap_clk);
        while (!cfg_valid) @(negedge ap_clk);
        foreach (w[i]) w[i] = exp_words.pop_front();
        compare_flags(cfg_flags, w[0][4:0], "cfg_flags");
        compare_index(cfg_index_start, w[1], "cfg_index_start");
        compare_index(cfg_index_end, w[2], "cfg_index_end");
        compare_index(cfg_stride, w[3], "cfg_stride");
        compare_granularity(cfg_granularity, w[4][4:0], "cfg_granularity");
        compare_bit(cfg_direction, w[4][31], "cfg_direction");
        compare_cmd(cfg_command, w[5][3:0], "cfg_command");
        compare_buffer_id(cfg_buffer_id, w[6][3:0], "cfg_buffer_id");
        compare_index(cfg_array_size, w[7], "cfg_array_size");
        repeat (gap) @(posedge ap_clk);
        @(posedge ap_clk);
        cfg_ready <= 1'b1;
        @(posedge ap_clk);
        cfg_ready <= 1'b0;
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge ap_clk);
            compare_bit(cfg_valid, 1'b0, "cfg_valid");
        end
    endtask

    // ----------------------------
    // Directed tests
    // ----------------------------
    task automatic in_order_sequence();
        run_sequence(1'b1);
        // cfg_valid due on the third edge after word 7 was driven
        expect_quiet(2);
        @(negedge ap_clk);
        compare_bit(cfg_valid, 1'b1, "cfg_valid");
        receive_config(0);
    endtask

    task automatic stray_offsets();
        fill_words();
        for (int i = 0; i < 8; i++) begin
            // Strays fall just below and just above the window
            send_response(csr_index_generator_pkg::offset_t'((i % 2 == 0) ? BASE - 1 - i
                                                                          : BASE + 7 + i),
                          lcg_next());
            send_response(csr_index_generator_pkg::offset_t'(BASE + i), seq_words[i]);
        end
        stop_responses();
        foreach (seq_words[i]) exp_words.push_back(seq_words[i]);
        receive_config(1);
    endtask

    task automatic out_of_order_abort();
        fill_words();
        send_words(0, 3);
        // Index 5 arrives where 4 is due and aborts the rest of the run
        send_response(csr_index_generator_pkg::offset_t'(BASE + 5), seq_words[5]);
        send_words(4, 7);
        stop_responses();
        expect_quiet(6);
        run_sequence(1'b1);
        receive_config(0);
    endtask

    task automatic midway_restart();
        fill_words();
        send_words(0, 4);
        // Index 0 follows index 4 directly
        run_sequence(1'b1);
        receive_config(0);
        expect_quiet(6);
    endtask

    task automatic queued_backpressure();
        repeat (5) run_sequence(1'b1);
        repeat (4) @(negedge ap_clk);
        compare_bit(overflow, 1'b0, "overflow");
        repeat (5) receive_config(int'(lcg_next() % 4));
        compare_bit(overflow, 1'b0, "overflow");
    endtask

    task automatic fifo_overflow();
        // Seventeenth configuration finds the FIFO full
        for (int n = 0; n < 17; n++) run_sequence(n < 16);
        repeat (4) @(negedge ap_clk);
        compare_bit(overflow, 1'b1, "overflow");
        repeat (16) receive_config(int'(lcg_next() % 3));
        expect_quiet(4);
    endtask

    initial begin
        lcg_state                  = 32'd14574;
        areset_csr_index_generator = 1'b1;
        resp_valid                 = 1'b0;
        resp_offset                = '0;
        resp_data                  = '0;
        cfg_ready                  = 1'b0;
        repeat (10) @(posedge ap_clk);
        areset_csr_index_generator <= 1'b0;
        in_order_sequence();
        stray_offsets();
        out_of_order_abort();
        midway_restart();
        queued_backpressure();
        fifo_overflow();
        repeat (2) @(posedge ap_clk);
        if (uut.u_assertions.failures == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("%0d assertion failures during the run", uut.u_assertions.failures);
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule : csr_index_generator_tb

// File: bench/csr_index_generator_assertions.sv
// ----------------------------
// Concurrent checks on the output
// handshake, overflow and reset state
// ----------------------------

module csr_index_generator_assertions (
    input logic                                   ap_clk,
    input logic                                   areset_csr_index_generator,
    input logic                                   cfg_ready,
    input logic                                   cfg_valid,
    input csr_index_generator_pkg::flags_t        cfg_flags,
    input csr_index_generator_pkg::index_t        cfg_index_start,
    input csr_index_generator_pkg::index_t        cfg_index_end,
    input csr_index_generator_pkg::index_t        cfg_stride,
    input csr_index_generator_pkg::granularity_t  cfg_granularity,
    input logic                                   cfg_direction,
    input csr_index_generator_pkg::cmd_t          cfg_command,
    input csr_index_generator_pkg::buffer_id_t    cfg_buffer_id,
    input csr_index_generator_pkg::index_t        cfg_array_size,
    input logic                                   overflow
);
    timeunit 1ns;
    timeprecision 1ps;

    // Count of failed assertions over the run
    int failures = 0;

    // Head entry holds while the consumer stalls
    hold_while_stalled: assert property (@(posedge ap_clk)
        disable iff (areset_csr_index_generator)
        cfg_valid && !cfg_ready |=> cfg_valid && $stable({cfg_flags, cfg_index_start,
            cfg_index_end, cfg_stride, cfg_granularity, cfg_direction, cfg_command,
            cfg_buffer_id, cfg_array_size}))
    else begin
        failures++;
        $error("cfg_valid or a cfg_ field changed while cfg_ready was low");
    end

    overflow_sticky: assert property (@(posedge ap_clk)
        disable iff (areset_csr_index_generator) overflow |=> overflow)
    else begin
        failures++;
        $error("overflow fell outside reset");
    end

    valid_low_in_reset: assert property (@(posedge ap_clk)
        areset_csr_index_generator |=> !cfg_valid)
    else begin
        failures++;
        $error("cfg_valid high after a reset edge");
    end

endmodule : csr_index_generator_assertions

bind csr_index_generator csr_index_generator_assertions u_assertions (.*);

// File: hw/csr_index_generator.sv
// ----------------------------
// CSR index configuration loader
// filter, tracker, decoder, FIFO
// ----------------------------

module csr_index_generator #(
    parameter csr_index_generator_pkg::offset_t SEQ_BASE = '0
) (
    input  logic                                   ap_clk,
    input  logic                                   areset_csr_index_generator,
    input  logic                                   resp_valid,
    input  csr_index_generator_pkg::offset_t       resp_offset,
    input  csr_index_generator_pkg::data_word_t    resp_data,
    input  logic                                   cfg_ready,
    output logic                                   cfg_valid,
    output csr_index_generator_pkg::flags_t        cfg_flags,
    output csr_index_generator_pkg::index_t        cfg_index_start,
    output csr_index_generator_pkg::index_t        cfg_index_end,
    output csr_index_generator_pkg::index_t        cfg_stride,
    output csr_index_generator_pkg::granularity_t  cfg_granularity,
    output logic                                   cfg_direction,
    output csr_index_generator_pkg::cmd_t          cfg_command,
    output csr_index_generator_pkg::buffer_id_t    cfg_buffer_id,
    output csr_index_generator_pkg::index_t        cfg_array_size,
    output logic                                   overflow
);

    // Filter outputs
    logic                                   word_valid;
    csr_index_generator_pkg::word_index_t   word_index;
    csr_index_generator_pkg::data_word_t    word_data;

    // Tracker outputs
    logic                                   capture;
    csr_index_generator_pkg::slot_t         slot;
    logic                                   complete;

    // Decoded configuration
    logic                                   push;
    csr_index_generator_pkg::flags_t        flags;
    csr_index_generator_pkg::index_t        index_start;
    csr_index_generator_pkg::index_t        index_end;
    csr_index_generator_pkg::index_t        stride;
    csr_index_generator_pkg::granularity_t  granularity;
    logic                                   direction;
    csr_index_generator_pkg::cmd_t          command;
    csr_index_generator_pkg::buffer_id_t    buffer_id;
    csr_index_generator_pkg::index_t        array_size;

    response_window_filter #(
        .SEQ_BASE(SEQ_BASE)
    ) u_filter (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .resp_valid                (resp_valid),
        .resp_offset               (resp_offset),
        .resp_data                 (resp_data),
        .word_valid                (word_valid),
        .word_index                (word_index),
        .word_data                 (word_data)
    );

    config_sequence_tracker u_tracker (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .word_valid                (word_valid),
        .word_index                (word_index),
        .capture                   (capture),
        .slot                      (slot),
        .complete                  (complete)
    );

    config_field_decoder u_decoder (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .capture                   (capture),
        .slot                      (slot),
        .complete                  (complete),
        .word_data                 (word_data),
        .push                      (push),
        .flags                     (flags),
        .index_start               (index_start),
        .index_end                 (index_end),
        .stride                    (stride),
        .granularity               (granularity),
        .direction                 (direction),
        .command                   (command),
        .buffer_id                 (buffer_id),
        .array_size                (array_size)
    );

    config_output_fifo u_fifo (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .push                      (push),
        .flags                     (flags),
        .index_start               (index_start),
        .index_end                 (index_end),
        .stride                    (stride),
        .granularity               (granularity),
        .direction                 (direction),
        .command                   (command),
        .buffer_id                 (buffer_id),
        .array_size                (array_size),
        .cfg_ready                 (cfg_ready),
        .cfg_valid                 (cfg_valid),
        .cfg_flags                 (cfg_flags),
        .cfg_index_start           (cfg_index_start),
        .cfg_index_end             (cfg_index_end),
        .cfg_stride                (cfg_stride),
        .cfg_granularity           (cfg_granularity),
        .cfg_direction             (cfg_direction),
        .cfg_command               (cfg_command),
        .cfg_buffer_id             (cfg_buffer_id),
        .cfg_array_size            (cfg_array_size),
        .overflow                  (overflow)
    );

endmodule : csr_index_generator

// File: hw/config_output_fifo.sv
// ----------------------------
// Configuration FIFO with valid/ready
// drain and sticky overflow flag
// ----------------------------

module config_output_fifo (
    input  logic                                   ap_clk,
    input  logic                                   areset_csr_index_generator,
    input  logic                                   push,
    input  csr_index_generator_pkg::flags_t        flags,
    input  csr_index_generator_pkg::index_t        index_start,
    input  csr_index_generator_pkg::index_t        index_end,
    input  csr_index_generator_pkg::index_t        stride,
    input  csr_index_generator_pkg::granularity_t  granularity,
    input  logic                                   direction,
    input  csr_index_generator_pkg::cmd_t          command,
    input  csr_index_generator_pkg::buffer_id_t    buffer_id,
    input  csr_index_generator_pkg::index_t        array_size,
    input  logic                                   cfg_ready,
    output logic                                   cfg_valid,
    output csr_index_generator_pkg::flags_t        cfg_flags,
    output csr_index_generator_pkg::index_t        cfg_index_start,
    output csr_index_generator_pkg::index_t        cfg_index_end,
    output csr_index_generator_pkg::index_t        cfg_stride,
    output csr_index_generator_pkg::granularity_t  cfg_granularity,
    output logic                                   cfg_direction,
    output csr_index_generator_pkg::cmd_t          cfg_command,
    output csr_index_generator_pkg::buffer_id_t    cfg_buffer_id,
    output csr_index_generator_pkg::index_t        cfg_array_size,
    output logic                                   overflow
);

    csr_index_generator_pkg::config_bits_t  mem [csr_index_generator_pkg::FIFO_DEPTH];
    csr_index_generator_pkg::config_bits_t  wr_entry;
    logic [$clog2(csr_index_generator_pkg::FIFO_DEPTH)-1:0]  wr_ptr;
    logic [$clog2(csr_index_generator_pkg::FIFO_DEPTH)-1:0]  rd_ptr;
    logic [$clog2(csr_index_generator_pkg::FIFO_DEPTH+1)-1:0] count;
    logic                                   full;
    logic                                   pop;
    logic                                   push_accept;

    assign wr_entry = {flags, index_start, index_end, stride, granularity,
                       direction, command, buffer_id, array_size};

    // Head entry straight onto the outputs
    assign {cfg_flags, cfg_index_start, cfg_index_end, cfg_stride, cfg_granularity,
            cfg_direction, cfg_command, cfg_buffer_id, cfg_array_size} = mem[rd_ptr];

    assign cfg_valid   = (count != '0);
    assign full        = (count == csr_index_generator_pkg::FIFO_DEPTH);
    assign pop         = cfg_valid & cfg_ready;
    // A full FIFO still takes the push when the head leaves in the same cycle
    assign push_accept = push & (~full | pop);

    always_ff @(posedge ap_clk) begin
        if (push_accept) begin
            mem[wr_ptr] <= wr_entry;
        end
    end

    // ----------------------------
    // Pointers, count, overflow
    // ----------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push_accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_accept, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (push && !push_accept) begin
                overflow <= 1'b1;
            end
        end
    end

endmodule : config_output_fifo

// File: hw/config_field_decoder.sv
// ----------------------------
// Field registers of one index
// generator configuration, loaded
// slot by slot from captured words
// ----------------------------

module config_field_decoder (
    input  logic                                   ap_clk,
    input  logic                                   areset_csr_index_generator,
    input  logic                                   capture,
    input  csr_index_generator_pkg::slot_t         slot,
    input  logic                                   complete,
    input  csr_index_generator_pkg::data_word_t    word_data,
    output logic                                   push,
    output csr_index_generator_pkg::flags_t        flags,
    output csr_index_generator_pkg::index_t        index_start,
    output csr_index_generator_pkg::index_t        index_end,
    output csr_index_generator_pkg::index_t        stride,
    output csr_index_generator_pkg::granularity_t  granularity,
    output logic                                   direction,
    output csr_index_generator_pkg::cmd_t          command,
    output csr_index_generator_pkg::buffer_id_t    buffer_id,
    output csr_index_generator_pkg::index_t        array_size
);

    // Push follows the slot 7 capture by one edge
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            push <= 1'b0;
        end else begin
            push <= complete;
        end
    end

    // ----------------------------
    // Field slicing per slot
    // ----------------------------
    always_ff @(posedge ap_clk) begin
        if (capture) begin
            if (slot[0]) begin
                // increment, decrement, mode_sequence, mode_buffer, mode_break
                flags <= word_data[csr_index_generator_pkg::FLAGS_W-1:0];
            end
            if (slot[1]) begin
                index_start <= word_data;
            end
            if (slot[2]) begin
                index_end <= word_data;
            end
            if (slot[3]) begin
                stride <= word_data;
            end
            if (slot[4]) begin
                granularity <= word_data[csr_index_generator_pkg::GRANULARITY_W-1:0];
                direction   <= word_data[csr_index_generator_pkg::DATA_W-1];
            end
            if (slot[5]) begin
                command <= word_data[csr_index_generator_pkg::CMD_W-1:0];
            end
            if (slot[6]) begin
                buffer_id <= word_data[csr_index_generator_pkg::BUFFER_ID_W-1:0];
            end
            if (slot[7]) begin
                array_size <= word_data;
            end
        end
    end

endmodule : config_field_decoder

// File: hw/config_sequence_tracker.sv
// ----------------------------
// Word order FSM, issues one-hot
// capture strobes per field slot
// ----------------------------

module config_sequence_tracker (
    input  logic                                  ap_clk,
    input  logic                                  areset_csr_index_generator,
    input  logic                                  word_valid,
    input  csr_index_generator_pkg::word_index_t  word_index,
    output logic                                  capture,
    output csr_index_generator_pkg::slot_t        slot,
    output logic                                  complete
);

    csr_index_generator_pkg::tracker_state_t  state;
    csr_index_generator_pkg::word_index_t     expected;
    logic                                     is_start;
    logic                                     is_next;

    assign is_start = (word_index == '0);
    assign is_next  = (state == csr_index_generator_pkg::COLLECT) && (word_index == expected);

    // Index 0 always (re)starts, otherwise only the expected index is taken
    assign capture  = word_valid & (is_start | is_next);
    assign slot     = csr_index_generator_pkg::slot_t'(1) << word_index;
    assign complete = capture & (word_index == csr_index_generator_pkg::NUM_WORDS - 1);

    // ----------------------------
    // State update
    // ----------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            state    <= csr_index_generator_pkg::IDLE;
            expected <= '0;
        end else if (capture) begin
            expected <= word_index + 1'b1;
            if (complete) begin
                state <= csr_index_generator_pkg::IDLE;
            end else begin
                state <= csr_index_generator_pkg::COLLECT;
            end
        end else if (word_valid && state == csr_index_generator_pkg::COLLECT) begin
            // Out of order word, drop the partial sequence
            state    <= csr_index_generator_pkg::IDLE;
            expected <= '0;
        end
    end

endmodule : config_sequence_tracker

// File: hw/response_window_filter.sv
// ----------------------------
// Input register stage and offset
// window filter for memory responses
// ----------------------------

module response_window_filter #(
    parameter csr_index_generator_pkg::offset_t SEQ_BASE = '0
) (
    input  logic                                  ap_clk,
    input  logic                                  areset_csr_index_generator,
    input  logic                                  resp_valid,
    input  csr_index_generator_pkg::offset_t      resp_offset,
    input  csr_index_generator_pkg::data_word_t   resp_data,
    output logic                                  word_valid,
    output csr_index_generator_pkg::word_index_t  word_index,
    output csr_index_generator_pkg::data_word_t   word_data
);

    logic                                 resp_valid_reg;
    csr_index_generator_pkg::offset_t     resp_offset_reg;
    csr_index_generator_pkg::data_word_t  resp_data_reg;
    csr_index_generator_pkg::offset_t     offset_diff;
    logic                                 in_window;

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            resp_valid_reg <= 1'b0;
        end else begin
            resp_valid_reg <= resp_valid;
        end
    end

    // Response payload
    always_ff @(posedge ap_clk) begin
        resp_offset_reg <= resp_offset;
        resp_data_reg   <= resp_data;
    end

    // Window test on the distance from the base so that base + 8 never wraps
    assign offset_diff = resp_offset_reg - SEQ_BASE;
    assign in_window   = (resp_offset_reg >= SEQ_BASE) &&
                         (offset_diff < csr_index_generator_pkg::NUM_WORDS);

    assign word_valid = resp_valid_reg & in_window;
    assign word_index = csr_index_generator_pkg::word_index_t'(offset_diff);
    assign word_data  = resp_data_reg;

endmodule : response_window_filter

// File: hw/csr_index_generator_pkg.sv
// ----------------------------
// Shared widths, vector types and the
// tracker state encoding for the CSR
// index configuration loader
// ----------------------------

package csr_index_generator_pkg;

    // Response stream
    localparam int DATA_W        = 32;
    localparam int OFFSET_W      = 16;

    // One configuration is a run of eight words
    localparam int NUM_WORDS     = 8;
    localparam int FIFO_DEPTH    = 16;

    // Field widths sliced out of the words
    localparam int FLAGS_W       = 5;
    localparam int GRANULARITY_W = 5;
    localparam int CMD_W         = 4;
    localparam int BUFFER_ID_W   = 4;

    // flags + four index values + granularity + direction + command + buffer id
    localparam int CONFIG_BITS   = FLAGS_W + 4 * DATA_W + GRANULARITY_W + 1
                                 + CMD_W + BUFFER_ID_W;

    typedef logic [DATA_W-1:0]              data_word_t;
    typedef logic [OFFSET_W-1:0]            offset_t;
    typedef logic [$clog2(NUM_WORDS)-1:0]   word_index_t;
    typedef logic [NUM_WORDS-1:0]           slot_t;

    typedef logic [DATA_W-1:0]              index_t;
    typedef logic [FLAGS_W-1:0]             flags_t;
    typedef logic [GRANULARITY_W-1:0]       granularity_t;
    typedef logic [CMD_W-1:0]               cmd_t;
    typedef logic [BUFFER_ID_W-1:0]         buffer_id_t;

    typedef logic [CONFIG_BITS-1:0]         config_bits_t;

    // Sequence tracker
    typedef enum logic {
        IDLE,
        COLLECT
    } tracker_state_t;

endpackage : csr_index_generator_pkg
